/* src.f */
+incdir+dv
source/firPkg.sv
source/frameTimer.sv
source/sampleWindow.sv
source/daLutBank.sv
source/outputStage.sv
source/firDecimatorTop.sv
dv/firDecimatorTb.sv

/* run.sh */
#!/bin/sh
# Compiles the decimator testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module firDecimatorTb \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
exit 0

/* dv/firRefModel.svh */
// arithmetic shift to the output width, then the sign bit flipped to offset binary.
function automatic logic [outWidth-1:0] offsetImage(input int total);
    int scaled;
    logic [outWidth-1:0] word;
    scaled = total >>> (nMant - (outWidth - 1));
    word = scaled[outWidth-1:0];                  // guard bits are simply dropped.
    word[outWidth-1] = ~word[outWidth-1];
    return word;
endfunction

// win[a] is the sample of age a; a 1 counts as +1 and a 0 as -1.
function automatic logic [outWidth-1:0] outFromWindow(input logic [tapCount-1:0] win);
    int aheadTotal;
    int backTotal;
    int total;
    aheadTotal = 0;
    backTotal = 0;
    for (int a = 0; a < halfTaps; a++) begin
        if (win[a]) begin
            aheadTotal += int'(hb[halfTaps-1-a]);
        end else begin
            aheadTotal -= int'(hb[halfTaps-1-a]);
        end
    end
    for (int a = halfTaps; a < tapCount; a++) begin
        if (win[a]) begin
            backTotal += int'(hf[a-halfTaps]);
        end else begin
            backTotal -= int'(hf[a-halfTaps]);
        end
    end
    if (tbOp == SUB) begin
        total = aheadTotal - backTotal;
    end else begin
        total = aheadTotal + backTotal;
    end
    return offsetImage(total);
endfunction

function automatic logic validAfter(input int tick);
    return (tick >= warmupTicks);                 // high from the first full-window tick on.
endfunction

function automatic int unsigned lcgNext(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

/* dv/firDecimatorTb.sv */
`timescale 1ns/10ps

module firDecimatorTb;

    import firPkg::*;

    localparam int OSR = 4;
    localparam combineOp_t tbOp = ADD;
    localparam int clkPeriod = 40;
    localparam int driveDelay = 2;
    localparam int lcgSeed = 23;
    localparam int maxEdges = 1024;
    localparam int warmupTicks = tapCount / OSR + 2;

    localparam int resetCycles = 2;
    localparam int resetTestCycles = (warmupTicks - 1) * OSR;
    localparam int constCycles = (warmupTicks + 4) * OSR;
    localparam int altCycles = tapCount * OSR;
    localparam int randCycles = 400;
    localparam int preResetCycles = 2 * OSR;
    localparam int rewarmCycles = (warmupTicks + 2) * OSR;
    localparam int testCycles = 5 * resetCycles + resetTestCycles + constCycles + altCycles
                              + randCycles + preResetCycles + rewarmCycles;
    localparam int cycleLimit = testCycles + 50;

    logic clk;
    logic rst;
    logic in;
    logic [outWidth-1:0] out;
    logic valid;

    logic histBits [maxEdges];                    // histBits[e] was sampled on edge e+1.
    int edgeCount;
    int tickCount;
    int cycleCount;
    int unsigned lcgState;

    `include "firRefModel.svh"

    firDecimatorTop #(.OSR(OSR), .combineOp(tbOp)) dut0 (
        .clk(clk),
        .rst(rst),
        .in(in),
        .out(out),
        .valid(valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    function automatic logic randomBit();
        lcgState = lcgNext(lcgState);
        return lcgState[16];
    endfunction

    function automatic logic [tapCount-1:0] windowAt(input int tick);
        logic [tapCount-1:0] win;
        int lastEdge;
        lastEdge = tick * OSR;
        for (int a = 0; a < tapCount; a++) begin
            if (lastEdge - a >= 1) begin
                win[a] = histBits[lastEdge-a-1];
            end else begin
                win[a] = 1'b0;                    // the window comes out of reset as zero bits.
            end
        end
        return win;
    endfunction

    // out after a tick reflects the window of two ticks earlier.
    function automatic logic [outWidth-1:0] expectedOut(input int tick);
        if (tick == 0) begin
            return '0;
        end else if (tick == 1) begin
            return offsetImage(0);                // half sums still hold their reset value.
        end else begin
            return outFromWindow(windowAt(tick - 2));
        end
    endfunction

    task automatic checkOutputs;
        logic [outWidth-1:0] expOut;
        logic expValid;
        expOut = expectedOut(tickCount);
        expValid = validAfter(tickCount);
        assert (out === expOut) else begin
            abortRun($sformatf("Mismatch at %0t: out = 0x%h, expected 0x%h",
                               $time, out, expOut));
        end
        assert (valid === expValid) else begin
            abortRun($sformatf("Mismatch at %0t: valid = %b, expected %b",
                               $time, valid, expValid));
        end
    endtask

    task automatic checkRiseTick(input int riseTick);
        assert (riseTick == warmupTicks) else begin
            abortRun($sformatf("valid rose on tick %0d instead of tick %0d",
                               riseTick, warmupTicks));
        end
    endtask

    task automatic applyReset;
        rst = 1'b0;
        in = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        rst = 1'b1;
        edgeCount = 0;
        tickCount = 0;
    endtask

    task automatic stepCycle(input logic bitValue);
        in = bitValue;
        @(posedge clk);
        assert (edgeCount < maxEdges) else begin
            abortRun("bit history overflowed without a reset");
        end
        histBits[edgeCount] = bitValue;
        edgeCount++;
        if (edgeCount % OSR == 0) begin
            tickCount++;
        end
        #driveDelay;
        checkOutputs();
    endtask

    task automatic resetStateTest;
        applyReset();
        assert (out === '0) else begin
            abortRun($sformatf("Mismatch at %0t: out = 0x%h, expected 0x0", $time, out));
        end
        checkOutputs();
        repeat (resetTestCycles) begin
            stepCycle(1'b0);
            assert (valid === 1'b0) else begin
                abortRun($sformatf("Mismatch at %0t: valid = %b, expected 0", $time, valid));
            end
        end
    endtask

    task automatic constantOnesTest;
        int sumAll;
        int riseTick;
        logic [outWidth-1:0] expOnes;
        sumAll = 0;
        riseTick = -1;
        for (int i = 0; i < halfTaps; i++) begin
            sumAll += int'(hb[i]);
            if (tbOp == SUB) begin
                sumAll -= int'(hf[i]);
            end else begin
                sumAll += int'(hf[i]);
            end
        end
        expOnes = offsetImage(sumAll);
        applyReset();
        repeat (constCycles) begin
            stepCycle(1'b1);
            if (valid && riseTick < 0) begin
                riseTick = tickCount;
            end
        end
        checkRiseTick(riseTick);
        assert (out === expOnes) else begin
            abortRun($sformatf("Mismatch at %0t: out = 0x%h, expected 0x%h",
                               $time, out, expOnes));
        end
    endtask

    // alternating bits expose any mix-up between the two half orders.
    task automatic alternatingTest;
        applyReset();
        for (int i = 0; i < altCycles; i++) begin
            stepCycle(((i % 2) == 0) ? 1'b1 : 1'b0);
        end
    endtask

    task automatic randomStreamTest;
        applyReset();
        repeat (randCycles) stepCycle(randomBit());
    endtask

    task automatic midStreamResetTest;
        int riseTick;
        riseTick = -1;
        repeat (preResetCycles) stepCycle(randomBit());
        assert (valid === 1'b1) else begin
            abortRun($sformatf("Mismatch at %0t: valid = %b, expected 1", $time, valid));
        end
        rst = 1'b0;
        #1;
        assert (out === '0) else begin
            abortRun($sformatf("Mismatch at %0t: out = 0x%h, expected 0x0", $time, out));
        end
        assert (valid === 1'b0) else begin
            abortRun($sformatf("Mismatch at %0t: valid = %b, expected 0", $time, valid));
        end
        applyReset();
        repeat (rewarmCycles) begin
            stepCycle(randomBit());
            if (valid && riseTick < 0) begin
                riseTick = tickCount;
            end
        end
        checkRiseTick(riseTick);
    endtask

    initial begin
        rst = 1'b0;
        in = 1'b0;
        edgeCount = 0;
        tickCount = 0;
        lcgState = lcgSeed;
        resetStateTest();
        constantOnesTest();
        alternatingTest();
        randomStreamTest();
        midStreamResetTest();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* source/firDecimatorTop.sv */
`timescale 1ns/10ps

module firDecimatorTop #(
    parameter int                 OSR = 4,
    parameter firPkg::combineOp_t combineOp = firPkg::ADD
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in,
    output logic [firPkg::outWidth-1:0] out,
    output logic                        valid
);

    import firPkg::*;

    logic frameTick;
    logic [$clog2(OSR)-1:0] bitIndex;
    logic [halfTaps-1:0] lookahead;
    logic [halfTaps-1:0] lookback;
    logic signed [sumWidth-1:0] aheadSum;
    logic signed [sumWidth-1:0] backSum;

    frameTimer #(.OSR(OSR)) timer (
        .clk(clk),
        .rst(rst),
        .frameTick(frameTick),
        .bitIndex(bitIndex)
    );

    sampleWindow #(.OSR(OSR)) window (
        .clk(clk),
        .rst(rst),
        .in(in),
        .frameTick(frameTick),
        .bitIndex(bitIndex),
        .lookahead(lookahead),
        .lookback(lookback)
    );

    daLutBank #(.coef(hb)) aheadBank (
        .clk(clk),
        .rst(rst),
        .frameTick(frameTick),
        .taps(lookahead),
        .halfSum(aheadSum)
    );

    daLutBank #(.coef(hf)) backBank (
        .clk(clk),
        .rst(rst),
        .frameTick(frameTick),
        .taps(lookback),
        .halfSum(backSum)
    );

    outputStage #(.combineOp(combineOp), .OSR(OSR)) outStage (
        .clk(clk),
        .rst(rst),
        .frameTick(frameTick),
        .aheadSum(aheadSum),
        .backSum(backSum),
        .out(out),
        .valid(valid)
    );

endmodule

/* source/outputStage.sv */
`timescale 1ns/10ps

module outputStage #(
    parameter firPkg::combineOp_t combineOp = firPkg::ADD,
    parameter int                 OSR = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               frameTick,
    input  logic signed [firPkg::sumWidth-1:0] aheadSum,
    input  logic signed [firPkg::sumWidth-1:0] backSum,
    output logic [firPkg::outWidth-1:0]        out,
    output logic                               valid
);

    import firPkg::*;

    localparam int shiftBits = nMant - (outWidth - 1);
    // window fill, then one tick for the half sums and one for out.
    localparam int warmupTicks = tapCount / OSR + 2;
    localparam int countWidth = $clog2(warmupTicks);

    logic signed [sumWidth-1:0] total;
    logic signed [sumWidth-1:0] scaled;
    logic [outWidth-1:0] offsetWord;
    logic [countWidth-1:0] tickCount;

    always_comb begin
        case (combineOp)
            SUB:     total = aheadSum - backSum;
            default: total = aheadSum + backSum;
        endcase
    end

    assign scaled = total >>> shiftBits;           // upper guard bits are dropped below.

    // Flipping the sign bit turns two's complement into offset binary.
    assign offsetWord = {~scaled[outWidth-1], scaled[outWidth-2:0]};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out <= '0;
        end else if (frameTick) begin
            out <= offsetWord;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tickCount <= '0;
            valid <= 1'b0;
        end else if (frameTick && !valid) begin
            tickCount <= tickCount + 1'b1;
            if (tickCount == countWidth'(warmupTicks - 1)) begin
                valid <= 1'b1;                     // this tick registers the first full window.
            end
        end
    end

    // the scaler does not saturate, so the dropped guard bits may only repeat the sign.
    noWrap: assert property (
        @(posedge clk) disable iff (!rst)
        frameTick |-> (scaled[sumWidth-1:outWidth-1] == '0
                       || scaled[sumWidth-1:outWidth-1] == '1)
    ) else $error("scaled sum wraps at the output width");

endmodule

/* source/daLutBank.sv */
`timescale 1ns/10ps

module daLutBank #(
    parameter firPkg::coefSlice_t coef = firPkg::hb
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              frameTick,
    input  logic [firPkg::halfTaps-1:0]       taps,
    output logic signed [firPkg::sumWidth-1:0] halfSum
);

    import firPkg::*;

    localparam int lutCount = halfTaps / lutSize;
    localparam int lutDepth = 2 ** lutSize;

    coef_t lutOut [lutCount];
    coef_t sumNext;

    // One ROM per group of lutSize taps, filled from the coefficient slice.
    generate
        for (genvar t = 0; t < lutCount; t++) begin : lutGen
            coef_t rom [lutDepth];

            for (genvar e = 0; e < lutDepth; e++) begin : entryGen
                localparam coef_t entryValue = lutEntry(coef, t * lutSize, lutSize'(e));
                assign rom[e] = entryValue;
            end

            assign lutOut[t] = rom[taps[t*lutSize +: lutSize]];   // taps address the ROM.
        end
    endgenerate

    // partial sums of the tables add up to the bipolar dot product of the half.
    always_comb begin
        sumNext = '0;
        for (int t = 0; t < lutCount; t++) begin
            sumNext = sumNext + lutOut[t];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            halfSum <= '0;
        end else if (frameTick) begin
            halfSum <= sumNext;
        end
    end

    // A gap in the frame bits upstream would show up here as X.
    knownSum: assert property (
        @(posedge clk) disable iff (!rst)
        !$isunknown(halfSum)
    ) else $error("halfSum unknown after reset");

endmodule

/* source/sampleWindow.sv */
`timescale 1ns/10ps

module sampleWindow #(
    parameter int OSR = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             in,
    input  logic                             frameTick,
    input  logic [$clog2(OSR)-1:0]           bitIndex,
    output logic [firPkg::halfTaps-1:0]      lookahead,
    output logic [firPkg::halfTaps-1:0]      lookback
);

    import firPkg::*;

    localparam int idxWidth = $clog2(OSR);
    localparam logic [idxWidth-1:0] lastIndex = idxWidth'(OSR - 1);

    // Bit 0 of the frame is the newest sample and comes straight from in on the tick.
    logic [OSR-1:1] frame;
    logic [tapCount-1:0] window;                  // window[a] holds the sample of age a.
    logic [idxWidth-1:0] framePos;

    assign framePos = lastIndex - bitIndex;

    // each bit lands in a fixed slot so the stored frame only toggles once per sample.
    always_ff @(posedge clk) begin
        if (bitIndex != lastIndex) begin
            frame[framePos] <= in;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            window <= '0;
        end else if (frameTick) begin
            window <= {window[tapCount-OSR-1:0], frame, in};
        end
    end

    // the lookahead half is mirrored so that bit i meets hb[i].
    always_comb begin
        for (int i = 0; i < halfTaps; i++) begin
            lookahead[i] = window[halfTaps-1-i];
        end
    end

    assign lookback = window[tapCount-1:halfTaps];

endmodule

/* source/frameTimer.sv */
`timescale 1ns/10ps

module frameTimer #(
    parameter int OSR = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   frameTick,
    output logic [$clog2(OSR)-1:0] bitIndex
);

    localparam int idxWidth = $clog2(OSR);
    localparam logic [idxWidth-1:0] lastIndex = idxWidth'(OSR - 1);

    // bitIndex doubles as the prescale counter.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bitIndex <= '0;
        end else if (bitIndex == lastIndex) begin
            bitIndex <= '0;
        end else begin
            bitIndex <= bitIndex + 1'b1;
        end
    end

    assign frameTick = (bitIndex == lastIndex);   // high while the last bit of a frame arrives.

    generate
        if (OSR > 1) begin : tickCheck
            // every stage is enabled by this pulse, so a double tick would skip a frame.
            singleTick: assert property (
                @(posedge clk) disable iff (!rst)
                frameTick |=> !frameTick
            ) else $error("frameTick high in two consecutive cycles");
        end
    endgenerate

endmodule

/* source/firPkg.sv */
package firPkg;

    localparam int tapCount = 16;                 // samples in the filter window.
    localparam int halfTaps = tapCount / 2;       // samples per window half.
    localparam int lutSize = 4;                   // window bits addressing one table.
    localparam int nMant = 14;                    // fraction bits of the internal sums.
    localparam int sumWidth = nMant + 4;          // four guard bits above the fraction.
    localparam int outWidth = 14;

    typedef logic signed [sumWidth-1:0] coef_t;
    typedef coef_t coefSlice_t [halfTaps];

    // Operation joining the lookahead and lookback half sums.
    typedef enum logic {
        ADD,
        SUB
    } combineOp_t;

    // hb[0] sits next to the window centre, hb[7] weights the newest sample.
    localparam coefSlice_t hb = '{
        2600,
        2200,
        1550,
        900,
        400,
        110,
        -40,
        -70
    };

    // hf[0] sits next to the window centre, hf[7] weights the oldest sample.
    localparam coefSlice_t hf = '{
        2550,
        2150,
        1500,
        880,
        380,
        90,
        -30,
        -60
    };

    // Each address bit selects +coef for a 1 sample and -coef for a 0 sample,
    // so one table entry holds the bipolar partial sum of lutSize taps.
    function automatic coef_t lutEntry(
        input coefSlice_t coef,
        input int first,
        input logic [lutSize-1:0] addr
    );
        coef_t acc;
        acc = '0;
        for (int j = 0; j < lutSize; j++) begin
            if (addr[j]) begin
                acc = acc + coef[first + j];
            end else begin
                acc = acc - coef[first + j];
            end
        end
        return acc;
    endfunction

endpackage
